//--- src/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

  typedef logic [7:0] spi_byte_t;   // one byte on the wire
  typedef logic [3:0] reg_addr_t;   // register bank index
  typedef logic [2:0] credit_t;     // free stream credits, 0..4

  localparam int        REG_COUNT      = 16;    // registers in the bank
  localparam credit_t   STREAM_CREDITS = 3'd4;  // credits after reset

  // command byte fields
  localparam int CMD_WRITE_BIT  = 7;  // set means write burst
  localparam int CMD_STREAM_BIT = 6;  // set (with bit 7 clear) means stream
  localparam int CMD_ADDR_MSB   = 3;  // start address in bits 3:0

  // status byte fields
  localparam int STAT_OVF_BIT    = 7;  // sticky overflow
  localparam int STAT_CREDIT_MSB = 2;  // free credits in bits 2:0

  typedef enum logic [1:0] {
    CMD_READ   = 2'd0,
    CMD_WRITE  = 2'd1,
    CMD_STREAM = 2'd2
  } cmd_kind_t;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // waiting for command byte
    ST_READ   = 2'd1,
    ST_WRITE  = 2'd2,
    ST_STREAM = 2'd3
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/spi_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

// byte-level handshake between the SPI shifter and the frame controller
interface spi_byte_if
  import spi_bridge_pkg::*;
();

  logic      rx_valid;      // one-cycle pulse per completed byte
  spi_byte_t rx_byte;       // byte just shifted in
  spi_byte_t tx_byte;       // next byte to shift out
  logic      frame_active;  // sampled ss, inverted

  modport shifter (
    output rx_valid,
    output rx_byte,
    output frame_active,
    input  tx_byte
  );

  modport ctrl (
    input  rx_valid,
    input  rx_byte,
    input  frame_active,
    output tx_byte
  );

endinterface

`default_nettype wire

//--- src/spi_byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_shifter
  import spi_bridge_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         sck,
  input  wire         ss,
  input  wire         mosi,
  output logic        miso,
  spi_byte_if.shifter link
);

  logic      sck_q;       // sampled sck
  logic      sck_old_q;   // previous sample, for edge detect
  logic      ss_q;        // sampled slave select
  logic      mosi_q;      // sampled mosi
  logic      sck_rise;
  logic      sck_fall;
  logic      last_bit;    // rising edge that completes a byte
  spi_byte_t data_q;      // shift register, MSB goes out first
  spi_byte_t rx_byte_q;
  logic      rx_valid_q;
  logic      miso_q;
  logic [2:0] bit_cnt_q;  // bits received in current byte

  assign sck_rise = ~sck_old_q & sck_q;
  assign sck_fall = sck_old_q & ~sck_q;
  assign last_bit = ~ss_q & sck_rise & (bit_cnt_q == 3'd7);

  // pin sampling, single register stage
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_q     <= 1'b0;
      sck_old_q <= 1'b0;
      ss_q      <= 1'b1;  // deselected
    end else begin
      sck_q     <= sck;
      sck_old_q <= sck_q;
      ss_q      <= ss;
    end
    mosi_q <= mosi;
  end

  // bit counter, byte strobe and miso
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt_q  <= 3'd0;
      rx_valid_q <= 1'b0;
      miso_q     <= 1'b1;  // idle high
    end else begin
      rx_valid_q <= last_bit;  // strobe one cycle after 8th rise
      if (ss_q) begin
        bit_cnt_q <= 3'd0;       // frame idle, restart count
        miso_q    <= data_q[7];  // present first bit early
      end else if (sck_rise) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;  // wraps after 8
      end else if (sck_fall) begin
        miso_q <= data_q[7];  // shift out on falling edge
      end
    end
  end

  // shift register, reloaded when idle or right after a byte
  always_ff @(posedge clk) begin
    if (ss_q || rx_valid_q) begin
      data_q <= link.tx_byte;
    end else if (sck_rise) begin
      data_q <= {data_q[6:0], mosi_q};  // MSB first in
    end
    if (last_bit) begin
      rx_byte_q <= {data_q[6:0], mosi_q};  // capture full byte
    end
  end

  assign miso              = miso_q;
  assign link.rx_valid     = rx_valid_q;
  assign link.rx_byte      = rx_byte_q;
  assign link.frame_active = ~ss_q;

  // the byte strobe must stay a single pulse for the controller
  a_rx_valid_pulse: assert property (
    @(posedge clk) disable iff (rst) link.rx_valid |=> !link.rx_valid
  ) else $error("rx_valid held for two cycles");

endmodule

`default_nettype wire

//--- src/spi_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_ctrl
  import spi_bridge_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  spi_byte_if.ctrl    link,
  output logic        wr_en,
  output reg_addr_t   wr_addr,
  output spi_byte_t   wr_data,
  output reg_addr_t   rd_addr,
  input  wire spi_byte_t rd_data,
  output logic        push,
  output spi_byte_t   push_data,
  input  wire         has_credit,
  input  wire credit_t credits
);

  ctrl_state_t state_q;
  reg_addr_t   ptr_q;        // burst address pointer
  logic        ovf_q;        // sticky stream overflow
  cmd_kind_t   cmd_kind;     // decode of the incoming byte
  spi_byte_t   status_byte;
  logic        byte_in;      // byte completed inside a frame
  logic        status_load;  // command done, status goes out next
  logic        stream_byte;
  logic        drop;         // stream byte with no credit

  // write wins over stream, stream over read
  function automatic cmd_kind_t decode_cmd(spi_byte_t cmd);
    if (cmd[CMD_WRITE_BIT]) begin
      return CMD_WRITE;
    end else if (cmd[CMD_STREAM_BIT]) begin
      return CMD_STREAM;
    end
    return CMD_READ;
  endfunction

  assign cmd_kind    = decode_cmd(link.rx_byte);
  assign byte_in     = link.rx_valid & link.frame_active;
  assign status_load = byte_in & (state_q == ST_IDLE);
  assign stream_byte = byte_in & (state_q == ST_STREAM);
  assign drop        = stream_byte & ~has_credit;

  always_comb begin
    status_byte                  = '0;
    status_byte[STAT_OVF_BIT]    = ovf_q;
    status_byte[STAT_CREDIT_MSB:0] = credits;
  end

  // register side, write lands on the rx_valid edge
  assign wr_en   = byte_in & (state_q == ST_WRITE);
  assign wr_addr = ptr_q;
  assign wr_data = link.rx_byte;
  assign rd_addr = ptr_q;

  // read data only once the status byte has gone out
  assign link.tx_byte = (state_q == ST_READ) ? rd_data : status_byte;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      ptr_q   <= '0;
      ovf_q   <= 1'b0;
      push    <= 1'b0;
    end else begin
      push <= stream_byte & has_credit;  // one cycle after rx_valid
      if (drop) begin
        ovf_q <= 1'b1;
      end else if (status_load) begin
        ovf_q <= 1'b0;  // reported, so clear
      end
      if (!link.frame_active) begin
        state_q <= ST_IDLE;  // ss high ends any burst
      end else if (link.rx_valid) begin
        case (state_q)
          ST_IDLE: begin
            ptr_q <= link.rx_byte[CMD_ADDR_MSB:0];  // start address
            case (cmd_kind)
              CMD_WRITE:  state_q <= ST_WRITE;
              CMD_STREAM: state_q <= ST_STREAM;
              default:    state_q <= ST_READ;
            endcase
          end
          ST_READ, ST_WRITE: ptr_q <= ptr_q + 4'd1;  // wraps 15 to 0
          default: ;  // stream keeps no pointer
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stream_byte) begin
      push_data <= link.rx_byte;
    end
  end

  // a byte goes to the bank or the stream, never both
  a_wr_push_excl: assert property (
    @(posedge clk) disable iff (rst) !(wr_en && push)
  ) else $error("wr_en and push high together");

endmodule

`default_nettype wire

//--- src/spi_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank
  import spi_bridge_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            wr_en,
  input  wire reg_addr_t wr_addr,
  input  wire spi_byte_t wr_data,
  input  wire reg_addr_t rd_addr,
  output spi_byte_t      rd_data
);

  spi_byte_t regs_q [REG_COUNT];  // the register file

  // synchronous write, whole bank cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_addr] <= wr_data;
    end
  end

  // async read so the controller can load miso in the same cycle
  assign rd_data = regs_q[rd_addr];

endmodule

`default_nettype wire

//--- src/stream_credit_tx.sv
`timescale 1ns/1ps
`default_nettype none

module stream_credit_tx
  import spi_bridge_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            push,
  input  wire spi_byte_t push_data,
  output logic           has_credit,
  output credit_t        credits,
  input  wire            credit_return,
  output logic           stream_valid,
  output spi_byte_t      stream_data
);

  credit_t   credit_q;  // free slots at the receiver
  logic      valid_q;
  spi_byte_t data_q;

  assign has_credit = (credit_q != '0);
  assign credits    = credit_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_q <= STREAM_CREDITS;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= push;  // one clock behind push
      case ({push, credit_return})
        2'b10:   credit_q <= credit_q - 3'd1;  // spent
        2'b01:   credit_q <= credit_q + 3'd1;  // returned
        default: credit_q <= credit_q;         // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      data_q <= push_data;
    end
  end

  assign stream_valid = valid_q;
  assign stream_data  = data_q;

  // controller must check has_credit before pushing
  a_push_has_credit: assert property (
    @(posedge clk) disable iff (rst) push |-> credit_q != '0
  ) else $error("push with no credit");

  // receiver may only return what it was given
  a_credit_max: assert property (
    @(posedge clk) disable iff (rst) credit_q <= STREAM_CREDITS
  ) else $error("credit count above limit");

endmodule

`default_nettype wire

//--- src/spi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top
  import spi_bridge_pkg::*;
(
  input  wire       clk,
  input  wire       rst,
  input  wire       sck,
  input  wire       ss,
  input  wire       mosi,
  output logic      miso,
  output logic      stream_valid,
  output spi_byte_t stream_data,
  input  wire       credit_return
);

  logic      wr_en;
  reg_addr_t wr_addr;
  spi_byte_t wr_data;
  reg_addr_t rd_addr;
  spi_byte_t rd_data;
  logic      push;
  spi_byte_t push_data;
  logic      has_credit;
  credit_t   credits;

  spi_byte_if link ();  // shifter to controller

  spi_byte_shifter u_shifter (
    .clk  (clk),
    .rst  (rst),
    .sck  (sck),
    .ss   (ss),
    .mosi (mosi),
    .miso (miso),
    .link (link)
  );

  spi_cmd_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .link       (link),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .push       (push),
    .push_data  (push_data),
    .has_credit (has_credit),
    .credits    (credits)
  );

  spi_reg_bank u_regs (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  stream_credit_tx u_stream (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_data     (push_data),
    .has_credit    (has_credit),
    .credits       (credits),
    .credit_return (credit_return),
    .stream_valid  (stream_valid),
    .stream_data   (stream_data)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  localparam time HALF_PERIOD = 20ns;  // 40 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

//--- testbench/spi_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_tb
  import spi_bridge_pkg::*;
();

  localparam int TOTAL_BYTES    = 53;                       // spi bytes over all tests
  localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 8 * 8 * 2;  // 8 sck periods of 8 clocks

  logic      clk;
  logic      rst;
  logic      sck;
  logic      ss;
  logic      mosi;
  logic      miso;
  logic      stream_valid;
  spi_byte_t stream_data;
  logic      credit_return;

  integer    seed;
  spi_byte_t tx_buf [20];         // bytes sent in one frame
  spi_byte_t rx_buf [20];         // bytes taken from miso
  spi_byte_t exp_miso [20];
  spi_byte_t exp_stream [$];
  spi_byte_t got_stream [$];
  spi_byte_t m_regs [REG_COUNT];  // model of the bank
  credit_t   m_credits;
  logic      m_ovf;
  int        n_checks;
  int        n_errors;
  int        n_failed;
  int        test_num;
  int        errs_at_start;

  tb_clock_gen clk_gen (.clk(clk));

  spi_bridge_top dut (
    .clk           (clk),
    .rst           (rst),
    .sck           (sck),
    .ss            (ss),
    .mosi          (mosi),
    .miso          (miso),
    .stream_valid  (stream_valid),
    .stream_data   (stream_data),
    .credit_return (credit_return)
  );

  always @(negedge clk) begin
    if (stream_valid === 1'b1) begin
      got_stream.push_back(stream_data);  // every byte leaving the stream port
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic spi_byte_t status_of(input logic ovf, input credit_t cr);
    return {ovf, 4'b0000, cr};  // overflow in bit 7, credits in 2:0
  endfunction

  // expected miso bytes of a frame, and the model state after it
  function automatic void model_frame(input int nbytes);
    int        i;
    reg_addr_t ptr;
    logic      is_write;
    logic      is_stream;
    logic      is_read;
    ptr         = tx_buf[0][3:0];
    is_write    = tx_buf[0][7];
    is_stream   = ~tx_buf[0][7] & tx_buf[0][6];
    is_read     = ~is_write & ~is_stream;
    exp_miso[0] = status_of(m_ovf, m_credits);  // loaded while ss high
    exp_miso[1] = exp_miso[0];                  // loaded as the command completes
    m_ovf       = 1'b0;                         // reported, so cleared
    for (i = 1; i < nbytes; i++) begin
      if (i + 1 < nbytes) begin
        exp_miso[i + 1] = is_read ? m_regs[ptr] : status_of(m_ovf, m_credits);
      end
      if (is_write) begin
        m_regs[ptr] = tx_buf[i];
      end else if (is_stream && m_credits != 3'd0) begin
        exp_stream.push_back(tx_buf[i]);
        m_credits = m_credits - 3'd1;
      end else if (is_stream) begin
        m_ovf = 1'b1;  // no credit, byte lost
      end
      ptr = ptr + 4'd1;  // wraps 15 to 0
    end
  endfunction

  task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
    n_checks++;
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_credit(input string name, input credit_t exp, input credit_t act);
    n_checks++;
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      n_errors++;
    end
  endtask

  // mode 0, mosi set while sck low, miso taken just before the rise
  task automatic shift_byte(input spi_byte_t tx, output spi_byte_t rx);
    spi_byte_t sh;
    sh = tx;
    rx = '0;
    repeat (8) begin
      sck  <= 1'b0;
      mosi <= sh[7];  // MSB first
      sh   = {sh[6:0], 1'b0};
      repeat (3) @(posedge clk);
      @(negedge clk);
      rx = {rx[6:0], miso};
      @(posedge clk);
      sck <= 1'b1;
      repeat (4) @(posedge clk);
    end
  endtask

  task automatic run_frame(input int nbytes);
    int        i;
    spi_byte_t got;
    model_frame(nbytes);
    @(posedge clk);
    ss <= 1'b0;
    repeat (4) @(posedge clk);
    for (i = 0; i < nbytes; i++) begin
      shift_byte(tx_buf[i], got);
      rx_buf[i] = got;
    end
    sck <= 1'b0;
    repeat (4) @(posedge clk);
    ss <= 1'b1;  // frame end
    repeat (8) @(posedge clk);
    for (i = 0; i < nbytes; i++) begin
      check_byte($sformatf("miso[%0d]", i), exp_miso[i], rx_buf[i]);
    end
  endtask

  task automatic fill_random(input int nbytes);
    int i;
    for (i = 1; i < nbytes; i++) begin
      tx_buf[i] = spi_byte_t'($random(seed));
    end
  endtask

  task automatic write_single(input reg_addr_t addr);
    tx_buf[0] = {4'b1000, addr};  // write command
    fill_random(2);
    run_frame(2);
  endtask

  task automatic read_status();
    tx_buf[0] = 8'h00;  // read, status comes back in byte 1
    fill_random(2);
    run_frame(2);
    check_credit("status credits", exp_miso[1][2:0], rx_buf[1][2:0]);
    check_bit("status overflow", exp_miso[1][7], rx_buf[1][7]);
  endtask

  task automatic return_credits(input int n);
    repeat (n) begin
      @(posedge clk);
      credit_return <= 1'b1;
      @(posedge clk);
      credit_return <= 1'b0;
      m_credits = m_credits + 3'd1;
    end
  endtask

  task automatic compare_stream();
    int i;
    i = 0;
    while (got_stream.size() < exp_stream.size() && i < 64) begin
      @(posedge clk);
      i++;
    end
    check_int("stream_valid pulses", exp_stream.size(), got_stream.size());
    for (i = 0; i < exp_stream.size() && i < got_stream.size(); i++) begin
      check_byte($sformatf("stream_data[%0d]", i), exp_stream[i], got_stream[i]);
    end
    exp_stream.delete();
    got_stream.delete();
  endtask

  task automatic start_test();
    test_num++;
    errs_at_start = n_errors;
  endtask

  task automatic end_test(input string name);
    compare_stream();
    if (n_errors == errs_at_start) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_num, name, n_errors - errs_at_start);
      n_failed++;
    end
  endtask

  initial begin
    int i;
    seed          = 32'he1ce_1aad;
    rst           = 1'b1;
    sck           = 1'b0;
    ss            = 1'b1;
    mosi          = 1'b0;
    credit_return = 1'b0;
    n_checks      = 0;
    n_errors      = 0;
    n_failed      = 0;
    test_num      = 0;
    m_credits     = STREAM_CREDITS;
    m_ovf         = 1'b0;
    for (i = 0; i < REG_COUNT; i++) begin
      m_regs[i] = '0;
    end

    start_test();
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_bit("miso", 1'b1, miso);  // reset value
    check_bit("stream_valid", 1'b0, stream_valid);
    @(posedge clk);
    rst <= 1'b0;  // 10 cycles of reset
    read_status();
    end_test("reset and first status");

    start_test();
    tx_buf[0] = 8'h8e;  // write burst from 14
    fill_random(6);
    run_frame(6);       // 14 15 0 1 2
    tx_buf[0] = 8'h0e;  // read back from 14
    fill_random(7);
    run_frame(7);
    end_test("write burst across wrap");

    start_test();
    write_single(4'd5);
    write_single(4'd9);
    write_single(4'd12);
    tx_buf[0] = 8'h03;  // read 3 to 13, most never written
    fill_random(13);
    run_frame(13);
    end_test("scattered writes");

    start_test();
    tx_buf[0] = 8'h40;  // stream, three bytes
    fill_random(4);
    run_frame(4);
    read_status();
    end_test("stream with credits");

    start_test();
    tx_buf[0] = 8'h40;  // one credit left, two bytes dropped
    fill_random(4);
    run_frame(4);
    read_status();      // overflow set
    read_status();      // overflow cleared
    return_credits(4);
    tx_buf[0] = 8'h40;
    fill_random(3);
    run_frame(3);
    read_status();
    end_test("stream overflow and credit return");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_num, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/spi_bridge_pkg.sv
src/spi_byte_if.sv
src/spi_byte_shifter.sv
src/spi_cmd_ctrl.sv
src/spi_reg_bank.sv
src/stream_credit_tx.sv
src/spi_bridge_top.sv
testbench/tb_clock_gen.sv
testbench/spi_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spi_bridge_tb -f list.f -o spi_bridge_sim

sim_out=$(./obj_dir/spi_bridge_sim)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "RESULT: PASS"; then
  exit 0
fi
exit 1
